// File: list.f
source/serial_alu_pkg.sv
source/serial_shifter.sv
source/serial_alu.sv
source/operand_regs.sv
source/alu_sequencer.sv
source/serial_alu_top.sv
tb/tb_clock.sv
tb/alu_checker.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f list.f --Mdir obj_dir -o sim
./obj_dir/sim | tee sim.log

if grep -q "^TEST OK$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top
   import serial_alu_pkg::*;
();

   localparam int          WIDTH      = 32;
   localparam int          SHAMT_W    = $clog2(WIDTH);
   localparam int          CLK_PERIOD = 100;
   localparam logic [31:0] SEED       = 32'hc20d139a;
   // Longest shift: shamt phase, run phase and a drain of up to two words.
   localparam int          MAX_LAT    = 3 * WIDTH + SHAMT_W + 8;

   localparam int N_CORNER = 4;
   localparam int N_RAND   = 16;
   localparam int N_SIGN   = 8;
   localparam int N_EQ     = 8;
   localparam int N_BUSY   = 3;
   localparam int N_MIX    = 40;
   localparam int N_OPS    = 2 * N_CORNER * N_CORNER + 8 * N_RAND + 2 * N_SIGN +
                             2 * N_EQ + 3 * WIDTH + N_BUSY + N_MIX;
   localparam int WATCHDOG_NS = (2 * N_OPS * MAX_LAT + 20) * CLK_PERIOD;

   localparam logic [WIDTH-1:0] MSB_ONLY = {1'b1, {(WIDTH-1){1'b0}}};
   localparam logic [WIDTH-1:0] SH_MASK  = WIDTH'(WIDTH - 1);

   logic             clk;
   logic             rst_n;
   logic             start;
   alu_op_e          op;
   logic [WIDTH-1:0] a;
   logic [WIDTH-1:0] b;
   logic             busy;
   logic             done;
   logic [WIDTH-1:0] result;
   logic             cmp;
   int               checks;
   int               value_errs;
   int               protocol_errs;

   tb_clock #(
      .PERIOD (CLK_PERIOD)
   ) clock_i (
      .clk     (clk),
      .o_rst_n (rst_n)
   );

   serial_alu_top #(
      .WIDTH (WIDTH)
   ) dut_i (
      .clk      (clk),
      .i_rst_n  (rst_n),
      .i_start  (start),
      .i_op     (op),
      .i_a      (a),
      .i_b      (b),
      .o_busy   (busy),
      .o_done   (done),
      .o_result (result),
      .o_cmp    (cmp)
   );

   alu_checker #(
      .WIDTH   (WIDTH),
      .MAX_LAT (MAX_LAT)
   ) checker_i (
      .clk             (clk),
      .i_rst_n         (rst_n),
      .i_start         (start),
      .i_op            (op),
      .i_a             (a),
      .i_b             (b),
      .i_busy          (busy),
      .i_done          (done),
      .i_result        (result),
      .i_cmp           (cmp),
      .o_checks        (checks),
      .o_value_errs    (value_errs),
      .o_protocol_errs (protocol_errs)
   );

   function automatic logic [WIDTH-1:0] random_word();
      logic [63:0] w;
      w = {$urandom(), $urandom()};
      return w[WIDTH-1:0];
   endfunction

   // Called on a rising edge; returns one edge later with the strobe dropped.
   task automatic drive_start(input alu_op_e o, input logic [WIDTH-1:0] x,
                              input logic [WIDTH-1:0] y);
      start <= 1'b1;
      op    <= o;
      a     <= x;
      b     <= y;
      @(posedge clk);
      start <= 1'b0;
   endtask

   // Returns on the edge that ends the done pulse, ready for the next start.
   task automatic wait_done();
      int waited;
      waited = 0;
      while (!done && waited < MAX_LAT + 8) begin
         @(posedge clk);
         waited++;
      end
   endtask

   task automatic run_op(input alu_op_e o, input logic [WIDTH-1:0] x,
                         input logic [WIDTH-1:0] y);
      drive_start(o, x, y);
      wait_done();
   endtask

   // A second strobe during busy carries other operands and must be ignored.
   task automatic run_with_stray_start(input alu_op_e o, input int delay);
      drive_start(o, random_word(), random_word());
      repeat (delay) @(posedge clk);
      drive_start(OP_XOR, random_word(), random_word());
      wait_done();
   endtask

   initial begin
      logic [WIDTH-1:0] corners [N_CORNER];
      logic [WIDTH-1:0] x;
      logic [WIDTH-1:0] y;
      void'($urandom(SEED));
      start <= 1'b0;
      op    <= OP_ADD;
      a     <= '0;
      b     <= '0;
      corners[0] = '0;
      corners[1] = '1;
      corners[2] = MSB_ONLY;
      corners[3] = WIDTH'(1);
      @(posedge clk);
      while (!rst_n) begin
         @(posedge clk);
      end

      foreach (corners[i]) begin
         foreach (corners[j]) begin
            run_op(OP_ADD, corners[i], corners[j]);
            run_op(OP_SUB, corners[i], corners[j]);
         end
      end
      repeat (N_RAND) begin
         run_op(OP_ADD, random_word(), random_word());
         run_op(OP_SUB, random_word(), random_word());
         run_op(OP_XOR, random_word(), random_word());
         run_op(OP_XNOR, random_word(), random_word());
         run_op(OP_OR, random_word(), random_word());
         run_op(OP_AND, random_word(), random_word());
         run_op(OP_SLT, random_word(), random_word());
         run_op(OP_SLTU, random_word(), random_word());
      end

      // Pairs that differ only in the sign bit.
      repeat (N_SIGN) begin
         x = random_word();
         y = x ^ MSB_ONLY;
         run_op(OP_SLT, x, y);
         run_op(OP_SLTU, x, y);
      end
      repeat (N_EQ) begin
         x = random_word();
         run_op(OP_EQ, x, x);
         run_op(OP_EQ, x, x ^ (WIDTH'(1) << $urandom_range(0, WIDTH - 1)));
      end

      for (int s = 0; s < WIDTH; s++) begin
         run_op(OP_SLL, random_word(), (random_word() & ~SH_MASK) | WIDTH'(s));
         run_op(OP_SRL, random_word(), (random_word() & ~SH_MASK) | WIDTH'(s));
         run_op(OP_SRA, random_word(), (random_word() & ~SH_MASK) | WIDTH'(s));
      end

      run_with_stray_start(OP_ADD, 0);
      run_with_stray_start(OP_SLT, 9);
      run_with_stray_start(OP_SRA, 18);

      repeat (N_MIX) begin
         run_op(alu_op_e'($urandom_range(0, 11)), random_word(), random_word());
      end

      repeat (4) @(posedge clk);
      $display("checks: %0d, value errors: %0d, protocol errors: %0d",
               checks, value_errs, protocol_errs);
      if (checks != N_OPS) begin
         $display("Expected %0d checked operations but saw %0d.", N_OPS, checks);
      end
      if (value_errs == 0 && protocol_errs == 0 && checks == N_OPS) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns before the tests finished.", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: tb/alu_checker.sv
`timescale 1ns/1ps

module alu_checker
   import serial_alu_pkg::*;
#(
   parameter int WIDTH   = 32,
   parameter int MAX_LAT = 112
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_start,
   input  alu_op_e          i_op,
   input  logic [WIDTH-1:0] i_a,
   input  logic [WIDTH-1:0] i_b,
   input  logic             i_busy,
   input  logic             i_done,
   input  logic [WIDTH-1:0] i_result,
   input  logic             i_cmp,
   output int               o_checks,
   output int               o_value_errs,
   output int               o_protocol_errs
);

   localparam int SHAMT_W = $clog2(WIDTH);

   typedef struct packed {
      logic             cmp;
      logic [WIDTH-1:0] result;
   } expect_t;

   typedef struct packed {
      alu_op_e          op;
      logic [WIDTH-1:0] a;
      logic [WIDTH-1:0] b;
   } request_t;

   request_t req;
   logic     pending = 1'b0;
   logic     reset_checked = 1'b0;
   int       age = 0;
   time      start_time = 0;
   int       n_checks = 0;
   int       n_value_errs = 0;
   int       n_protocol_errs = 0;

   // Expected result and flag from the operation definitions.
   function automatic expect_t reference(alu_op_e op, logic [WIDTH-1:0] a,
                                         logic [WIDTH-1:0] b);
      expect_t            e;
      logic [SHAMT_W-1:0] sh;
      logic               lt;
      e  = '0;
      sh = b[SHAMT_W-1:0];
      case (op)
         OP_ADD:  e.result = a + b;
         OP_SUB:  e.result = a - b;
         OP_XOR:  e.result = a ^ b;
         OP_XNOR: e.result = ~(a ^ b);
         OP_OR:   e.result = a | b;
         OP_AND:  e.result = a & b;
         OP_SLT: begin
            lt       = ($signed(a) < $signed(b));
            e.cmp    = lt;
            e.result = {{(WIDTH-1){1'b0}}, lt};
         end
         OP_SLTU: begin
            lt       = (a < b);
            e.cmp    = lt;
            e.result = {{(WIDTH-1){1'b0}}, lt};
         end
         OP_EQ:   e.cmp = (a == b);
         OP_SLL:  e.result = a << sh;
         OP_SRL:  e.result = a >> sh;
         OP_SRA:  e.result = $signed(a) >>> sh;
         default: e = '0;
      endcase
      return e;
   endfunction

   function automatic logic is_shift(alu_op_e op);
      return op inside {OP_SLL, OP_SRL, OP_SRA};
   endfunction

   // A less-than flag needs a second pass to reach bit zero of the result.
   function automatic int run_cycles(alu_op_e op);
      return (op inside {OP_SLT, OP_SLTU}) ? 2 * WIDTH : WIDTH;
   endfunction

   // Sampled on the falling edge between updates.
   always @(negedge clk) begin
      expect_t exp_v;
      alu_op_e op_v;
      logic    busy_exp;
      if (!i_rst_n) begin
         pending       = 1'b0;
         reset_checked = 1'b0;
         age           = 0;
      end else begin
         busy_exp = pending;
         if (!reset_checked) begin
            reset_checked = 1'b1;
            if (i_busy !== 1'b0 || i_done !== 1'b0 || i_result !== '0 || i_cmp !== 1'b0) begin
               $display("error at %0d ns: outputs not cleared by reset", $time);
               n_protocol_errs++;
            end
         end
         // Busy covers every cycle from the one after the start to the done pulse.
         if (i_busy !== busy_exp) begin
            $display("error at %0d ns: busy is %b, expected %b", $time, i_busy, busy_exp);
            n_protocol_errs++;
         end
         if (i_done) begin
            if (!pending) begin
               $display("A done pulse arrived at %0d ns with no operation in flight.", $time);
               n_protocol_errs++;
            end else begin
               op_v  = req.op;
               exp_v = reference(req.op, req.a, req.b);
               n_checks++;
               if (i_result !== exp_v.result || i_cmp !== exp_v.cmp) begin
                  $display("error at %0d ns: %s a=%h b=%h gave %h cmp %b, expected %h cmp %b",
                           $time, op_v.name(), req.a, req.b, i_result, i_cmp,
                           exp_v.result, exp_v.cmp);
                  n_value_errs++;
               end
               // Latency counts the start cycle and the done cycle.
               if (!is_shift(req.op) && age != run_cycles(req.op)) begin
                  $display("error at %0d ns: %s took %0d cycles, expected %0d",
                           $time, op_v.name(), age + 2, run_cycles(req.op) + 2);
                  n_value_errs++;
               end
               pending = 1'b0;
            end
         end
         if (pending) begin
            age++;
            if (age > MAX_LAT) begin
               op_v = req.op;
               $display("The %s operation accepted at %0d ns never completed.",
                        op_v.name(), start_time);
               n_protocol_errs++;
               pending = 1'b0;
            end
         end
         if (i_start && !busy_exp) begin
            req.op     = i_op;
            req.a      = i_a;
            req.b      = i_b;
            pending    = 1'b1;
            age        = 0;
            start_time = $time;
         end
      end
   end

   assign o_checks        = n_checks;
   assign o_value_errs    = n_value_errs;
   assign o_protocol_errs = n_protocol_errs;

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD = 100
) (
   output logic clk,
   output logic o_rst_n
);

   // Reset is released on the second rising edge.
   initial begin
      clk     = 1'b0;
      o_rst_n = 1'b0;
      repeat (2) @(posedge clk);
      o_rst_n <= 1'b1;
   end

   always #(PERIOD / 2) clk = ~clk;

endmodule

// File: source/serial_alu_top.sv
`timescale 1ns/1ps

module serial_alu_top
   import serial_alu_pkg::*;
#(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_start,
   input  alu_op_e          i_op,
   input  logic [WIDTH-1:0] i_a,
   input  logic [WIDTH-1:0] i_b,
   output logic             o_busy,
   output logic             o_done,
   output logic [WIDTH-1:0] o_result,
   output logic             o_cmp
);

   localparam int SHAMT_W = $clog2(WIDTH);

   alu_ctrl_t ctrl;
   logic      load;
   logic      shift;
   logic      rs1;
   logic      op_b;
   logic      buf_bit;
   logic      rd;
   logic      cmp_bit;
   logic      sh_done;

   alu_sequencer #(
      .WIDTH (WIDTH)
   ) sequencer_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_start   (i_start),
      .i_op      (i_op),
      .i_cmp_bit (cmp_bit),
      .i_sh_done (sh_done),
      .o_ctrl    (ctrl),
      .o_load    (load),
      .o_shift   (shift),
      .o_busy    (o_busy),
      .o_done    (o_done),
      .o_cmp     (o_cmp)
   );

   operand_regs #(
      .WIDTH (WIDTH)
   ) regs_i (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_load   (load),
      .i_shift  (shift),
      .i_a      (i_a),
      .i_b      (i_b),
      .i_rd     (rd),
      .o_rs1    (rs1),
      .o_op_b   (op_b),
      .o_buf    (buf_bit),
      .o_result (o_result)
   );

   serial_alu #(
      .SHAMT_W (SHAMT_W)
   ) alu_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_ctrl    (ctrl),
      .i_rs1     (rs1),
      .i_op_b    (op_b),
      .i_buf     (buf_bit),
      .o_cmp     (cmp_bit),
      .o_sh_done (sh_done),
      .o_rd      (rd)
   );

endmodule

// File: source/alu_sequencer.sv
`timescale 1ns/1ps

module alu_sequencer
   import serial_alu_pkg::*;
#(
   parameter int WIDTH = 32
) (
   input  logic      clk,
   input  logic      i_rst_n,
   input  logic      i_start,
   input  alu_op_e   i_op,
   input  logic      i_cmp_bit,
   input  logic      i_sh_done,
   output alu_ctrl_t o_ctrl,
   output logic      o_load,
   output logic      o_shift,
   output logic      o_busy,
   output logic      o_done,
   output logic      o_cmp
);

   localparam int CNT_W = $clog2(WIDTH);

   seq_state_e       state_q;
   alu_ctrl_t        ctrl_q;
   logic [CNT_W-1:0] bit_cnt_q;
   logic             first_bit;
   logic             last_bit;
   logic             is_shift;
   logic             is_lt;

   function automatic alu_ctrl_t decode(alu_op_e op);
      alu_ctrl_t c;
      c = '0;
      case (op)
         OP_ADD:  c.rd_sel = RD_ADD;
         OP_SUB:  begin c.rd_sel = RD_ADD; c.sub = 1'b1; end
         OP_XOR:  begin c.rd_sel = RD_BOOL; c.bool_op = BOOL_XOR; end
         OP_XNOR: begin c.rd_sel = RD_BOOL; c.bool_op = BOOL_XNOR; end
         OP_OR:   begin c.rd_sel = RD_BOOL; c.bool_op = BOOL_OR; end
         OP_AND:  begin c.rd_sel = RD_BOOL; c.bool_op = BOOL_AND; end
         OP_SLT:  c.rd_sel = RD_CMP;
         OP_SLTU: begin c.rd_sel = RD_CMP; c.cmp_uns = 1'b1; end
         // Flag only, result stays zero.
         OP_EQ:   c.cmp_eq = 1'b1;
         OP_SLL:  c.rd_sel = RD_SH;
         OP_SRL:  begin c.rd_sel = RD_SH; c.sh_right = 1'b1; end
         OP_SRA:  begin c.rd_sel = RD_SH; c.sh_right = 1'b1; c.sh_signed = 1'b1; end
         default: c.rd_sel = RD_ADD;
      endcase
      return c;
   endfunction

   assign first_bit = (bit_cnt_q == '0);
   assign last_bit  = (bit_cnt_q == CNT_W'(WIDTH - 1));
   assign is_shift  = ctrl_q.rd_sel[1];
   assign is_lt     = ctrl_q.rd_sel[2];

   // Less-than needs a second pass to bring its flag down to bit zero.
   always_comb begin
      o_ctrl          = ctrl_q;
      o_ctrl.en       = (state_q == S_SHAMT) || (state_q == S_RUN);
      o_ctrl.shamt_en = (state_q == S_SHAMT);
      o_ctrl.cnt_done = (state_q == S_RUN) && last_bit;
      o_ctrl.init     = first_bit && (((state_q == S_RUN) && is_shift) ||
                                      ((state_q == S_DRAIN) && !is_shift));
   end

   assign o_load  = (state_q == S_IDLE) && i_start;
   assign o_shift = (state_q == S_SHAMT) || (state_q == S_RUN) || (state_q == S_DRAIN);
   assign o_busy  = (state_q != S_IDLE);
   assign o_done  = (state_q == S_DONE);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q   <= S_IDLE;
         ctrl_q    <= '0;
         bit_cnt_q <= '0;
         o_cmp     <= 1'b0;
      end else begin
         bit_cnt_q <= bit_cnt_q + 1'b1;
         case (state_q)
            S_IDLE: begin
               bit_cnt_q <= '0;
               if (i_start) begin
                  ctrl_q  <= decode(i_op);
                  state_q <= (i_op inside {OP_SLL, OP_SRL, OP_SRA}) ? S_SHAMT : S_RUN;
               end
            end
            S_SHAMT: begin
               if (bit_cnt_q == CNT_W'(CNT_W - 1)) begin
                  bit_cnt_q <= '0;
                  state_q   <= S_RUN;
               end
            end
            S_RUN: begin
               if (last_bit) begin
                  o_cmp     <= (is_lt || ctrl_q.cmp_eq) & i_cmp_bit;
                  bit_cnt_q <= '0;
                  state_q   <= (is_shift || is_lt) ? S_DRAIN : S_DONE;
               end
            end
            S_DRAIN: begin
               if (is_shift ? i_sh_done : last_bit) begin
                  state_q <= S_DONE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

endmodule

// File: source/operand_regs.sv
`timescale 1ns/1ps

module operand_regs #(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_load,
   input  logic             i_shift,
   input  logic [WIDTH-1:0] i_a,
   input  logic [WIDTH-1:0] i_b,
   input  logic             i_rd,
   output logic             o_rs1,
   output logic             o_op_b,
   output logic             o_buf,
   output logic [WIDTH-1:0] o_result
);

   logic [WIDTH-1:0] a_q;
   logic [WIDTH-1:0] b_q;
   logic [WIDTH-1:0] buf_q;
   logic [WIDTH-1:0] result_q;

   always_ff @(posedge clk) begin
      if (i_load) begin
         a_q   <= i_a;
         b_q   <= i_b;
         buf_q <= i_a;
      end else if (i_shift) begin
         a_q   <= {1'b0, a_q[WIDTH-1:1]};
         b_q   <= {1'b0, b_q[WIDTH-1:1]};
         // Buffer rotates, so A comes round again for long shifts.
         buf_q <= {buf_q[0], buf_q[WIDTH-1:1]};
      end
   end

   // New bits enter at the top; the first one ends up in bit zero.
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         result_q <= '0;
      end else if (i_shift) begin
         result_q <= {i_rd, result_q[WIDTH-1:1]};
      end
   end

   assign o_rs1    = a_q[0];
   assign o_op_b   = b_q[0];
   assign o_buf    = buf_q[0];
   assign o_result = result_q;

endmodule

// File: source/serial_alu.sv
`timescale 1ns/1ps

module serial_alu
   import serial_alu_pkg::*;
#(
   parameter int SHAMT_W = 5
) (
   input  logic      clk,
   input  logic      i_rst_n,
   input  alu_ctrl_t i_ctrl,
   input  logic      i_rs1,
   input  logic      i_op_b,
   input  logic      i_buf,
   output logic      o_cmp,
   output logic      o_sh_done,
   output logic      o_rd
);

   // Indexed by {bool_op, rs1, op_b} with xor, xnor, or and and in order.
   localparam logic [15:0] BOOL_LUT = 16'h8e96;

   logic               en_q;
   logic               add_cy_q;
   logic               neg_cy_q;
   logic               lt_q;
   logic               eq_q;
   logic               lt_res_q;
   logic [SHAMT_W-1:0] shamt_q;
   logic               shamt_msb_q;

   logic plus_one;
   logic neg_b;
   logic neg_cy;
   logic add_b;
   logic add_res;
   logic add_cy;
   logic bit_eq;
   logic lt_sign;
   logic res_lt;
   logic res_eq;
   logic res_bool;
   logic res_sh;
   logic shamt_ser;

   // The +1 of the two's complement of B goes in on the first enabled cycle.
   assign plus_one       = i_ctrl.en & ~en_q;
   assign {neg_cy, neg_b} = {1'b0, ~i_op_b} + plus_one + neg_cy_q;

   assign add_b            = i_ctrl.sub ? neg_b : i_op_b;
   assign {add_cy, add_res} = i_rs1 + add_b + add_cy_q;

   // The sign bit flips the sense of a signed compare.
   assign bit_eq  = (i_rs1 == i_op_b);
   assign lt_sign = i_ctrl.cnt_done & ~i_ctrl.cmp_uns;
   assign res_lt  = bit_eq ? lt_q : (i_op_b ^ lt_sign);
   assign res_eq  = bit_eq & eq_q;
   assign o_cmp   = i_ctrl.cmp_eq ? res_eq : res_lt;

   assign res_bool = BOOL_LUT[{i_ctrl.bool_op, i_rs1, i_op_b}];

   // Left shifts take the negated amount.
   assign shamt_ser = i_ctrl.sh_right ? i_op_b : neg_b;

   serial_shifter #(
      .SHAMT_W (SHAMT_W)
   ) shifter_i (
      .clk         (clk),
      .i_load      (i_ctrl.init),
      .i_shamt     (shamt_q),
      .i_shamt_msb (shamt_msb_q),
      .i_signbit   (i_ctrl.sh_signed & i_buf),
      .i_right     (i_ctrl.sh_right),
      .i_d         (i_buf),
      .o_done      (o_sh_done),
      .o_q         (res_sh)
   );

   // Init marks bit zero, where the less-than flag lands.
   assign o_rd = |(i_ctrl.rd_sel & {res_bool, lt_res_q & i_ctrl.init, res_sh, add_res});

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         en_q     <= 1'b0;
         add_cy_q <= 1'b0;
         neg_cy_q <= 1'b0;
         lt_q     <= 1'b0;
         eq_q     <= 1'b1;
         lt_res_q <= 1'b0;
      end else begin
         en_q     <= i_ctrl.en;
         add_cy_q <= i_ctrl.en & add_cy;
         neg_cy_q <= i_ctrl.en & neg_cy;
         lt_q     <= i_ctrl.en & res_lt;
         eq_q     <= res_eq | ~i_ctrl.en;
         if (i_ctrl.en) begin
            lt_res_q <= res_lt;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_ctrl.shamt_en) begin
         shamt_q     <= {shamt_ser, shamt_q[SHAMT_W-1:1]};
         // Only a left shift by zero carries into the top bit.
         shamt_msb_q <= neg_cy & ~i_ctrl.sh_right;
      end
   end

endmodule

// File: source/serial_shifter.sv
`timescale 1ns/1ps

module serial_shifter #(
   parameter int SHAMT_W = 5
) (
   input  logic               clk,
   input  logic               i_load,
   input  logic [SHAMT_W-1:0] i_shamt,
   input  logic               i_shamt_msb,
   input  logic               i_signbit,
   input  logic               i_right,
   input  logic               i_d,
   output logic               o_done,
   output logic               o_q
);

   localparam int CW = SHAMT_W + 2;
   // Load happens SHAMT_W+1 cycles into the stream; the counter then reaches
   // the amount exactly when the rotating buffer has passed 2*WIDTH bits.
   localparam logic [CW-1:0] LOAD_BASE = CW'((2 << SHAMT_W) - SHAMT_W - 1);

   logic [CW-1:0] cnt_q;
   logic [CW-1:0] amount;
   logic          fill_q;
   logic          wrapped;

   assign amount  = CW'({i_shamt_msb, i_shamt});
   assign wrapped = (cnt_q <= amount);

   always_ff @(posedge clk) begin
      if (i_load) begin
         cnt_q <= LOAD_BASE + amount;
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;
      end
      // Buffer shows the top data bit one cycle before the wrap.
      if (cnt_q == amount + CW'(1)) begin
         fill_q <= i_signbit & i_right;
      end
   end

   assign o_done = (cnt_q == CW'(1));

   // Right shifts pass data before the wrap, left shifts after it.
   assign o_q = (wrapped ^ i_right) ? i_d : (fill_q & i_right);

endmodule

// File: source/serial_alu_pkg.sv
package serial_alu_pkg;

   // Operation codes presented on i_op.
   typedef enum logic [3:0] {
      OP_ADD,
      OP_SUB,
      OP_XOR,
      OP_XNOR,
      OP_OR,
      OP_AND,
      OP_SLT,
      OP_SLTU,
      OP_EQ,
      OP_SLL,
      OP_SRL,
      OP_SRA
   } alu_op_e;

   typedef enum logic [2:0] {
      S_IDLE,
      S_SHAMT,
      S_RUN,
      S_DRAIN,
      S_DONE
   } seq_state_e;

   // One-hot result select: adder, shifter, compare, boolean.
   typedef logic [3:0] rd_sel_t;
   // Index into the boolean lookup table.
   typedef logic [1:0] bool_op_t;

   localparam rd_sel_t RD_ADD  = 4'b0001;
   localparam rd_sel_t RD_SH   = 4'b0010;
   localparam rd_sel_t RD_CMP  = 4'b0100;
   localparam rd_sel_t RD_BOOL = 4'b1000;

   localparam bool_op_t BOOL_XOR  = 2'd0;
   localparam bool_op_t BOOL_XNOR = 2'd1;
   localparam bool_op_t BOOL_OR   = 2'd2;
   localparam bool_op_t BOOL_AND  = 2'd3;

   typedef struct packed {
      logic     en;
      logic     init;
      logic     cnt_done;
      logic     shamt_en;
      logic     sub;
      bool_op_t bool_op;
      logic     cmp_eq;
      logic     cmp_uns;
      logic     sh_right;
      logic     sh_signed;
      rd_sel_t  rd_sel;
   } alu_ctrl_t;

endpackage
